//--- design/sha3_pad_pkg.sv
/*
  Shared widths, the Keccak rate table, state and mux encodings and the
  function padding constants of the SHA-3 padding unit.
  Modules pull these in with a wildcard import in their body.
*/
package sha3_pad_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // message and keccak data paths are one 64-bit lane wide
  localparam int msg_width      = 64;
  localparam int msg_strb_w     = msg_width / 8;
  // word address into the rate part of the 1600-bit state
  localparam int keccak_addr_w  = 5;
  // the counter must reach the largest rate, which is 21 words
  localparam int keccak_count_w = 5;
  // encode_string(N) || encode_string(S), prepared by software
  localparam int ns_bytes       = 46;
  // two bytepad header bytes plus the N/S string give 48 bytes
  localparam int prefix_words   = 6;

  ////////////////////////////////////////
  // configuration encodings
  ////////////////////////////////////////

  typedef enum logic [2:0] {l128, l224, l256, l384, l512} keccak_strength_e;

  // rate in 64-bit words, indexed by strength
  localparam int keccak_rate [5] = '{21, 18, 17, 13, 9};

  typedef enum logic [1:0] {sha3, shake, cshake} sha3_mode_e;

  // domain bits followed by the first 1 of pad10*1, LSB first
  localparam logic [4:0] funcpad_sha3   = 5'b00110;
  localparam logic [4:0] funcpad_shake  = 5'b11111;
  localparam logic [4:0] funcpad_cshake = 5'b00100;
  // no domain bits, only the leading 1 of pad10*1
  localparam logic [4:0] funcpad_none   = 5'b00001;

  ////////////////////////////////////////
  // FSM and mux encodings
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    st_idle,
    st_prefix,
    st_prefix_wait,
    st_message,
    st_message_wait,
    st_pad,
    st_pad_run,
    st_pad01,
    st_pad_flush
  } pad_st_e;

  typedef enum logic [2:0] {
    mux_none,
    mux_fifo,
    mux_prefix,
    mux_funcpad,
    mux_zero_end
  } mux_sel_e;

endpackage

//--- design/pad_config.sv
/*
  Operation configuration. Mode and strength are captured on start and
  held for the whole operation, then turned into the block size in words,
  the function pad bits and the two-byte bytepad header for cSHAKE.
*/
`timescale 1ns/1ps

module pad_config (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    start_i,
  input  sha3_pad_pkg::sha3_mode_e                mode_i,
  input  sha3_pad_pkg::keccak_strength_e          strength_i,
  output logic                                    is_cshake_o,
  output logic [sha3_pad_pkg::keccak_count_w-1:0] block_limit_o,
  output logic [4:0]                              funcpad_o,
  output logic [15:0]                             bytepad_hdr_o
);
  import sha3_pad_pkg::*;

  sha3_mode_e       mode_q;
  keccak_strength_e strength_q;

  // software may rewrite the config registers mid-operation, so only the
  // value seen at start counts
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q     <= sha3;
      strength_q <= l256;
    end else if (start_i) begin
      mode_q     <= mode_i;
      strength_q <= strength_i;
    end
  end

  assign is_cshake_o = (mode_q == cshake);

  // block size in words, also the address where pad10*1 ends
  always_comb begin
    unique case (strength_q)
      l128:    block_limit_o = keccak_count_w'(keccak_rate[l128]);
      l224:    block_limit_o = keccak_count_w'(keccak_rate[l224]);
      l256:    block_limit_o = keccak_count_w'(keccak_rate[l256]);
      l384:    block_limit_o = keccak_count_w'(keccak_rate[l384]);
      l512:    block_limit_o = keccak_count_w'(keccak_rate[l512]);
      default: block_limit_o = '0;
    endcase
  end

  always_comb begin
    unique case (mode_q)
      sha3:    funcpad_o = funcpad_sha3;
      shake:   funcpad_o = funcpad_shake;
      cshake:  funcpad_o = funcpad_cshake;
      default: funcpad_o = funcpad_none;
    endcase
  end

  // left_encode(rate in bytes): length byte 0x01 first, then words times 8
  assign bytepad_hdr_o = {block_limit_o, 3'b000, 8'h01};

  // every legal strength gives a real block size once start is captured
  block_limit_nonzero_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    start_i |=> block_limit_o != '0);

endmodule

//--- design/pad_fsm.sv
/*
  Padding control FSM. Sequences prefix, message, function pad and zero
  fill, counts the beats of each block, asks the permutation to run when
  a block is full and pulses absorbed after the final permutation.
*/
`timescale 1ns/1ps

module pad_fsm (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    start_i,
  input  logic                                    process_i,
  input  logic                                    done_i,
  input  sha3_pad_pkg::sha3_mode_e                mode_i,
  input  logic [sha3_pad_pkg::keccak_count_w-1:0] block_limit_i,
  input  logic                                    msg_valid_i,
  input  logic                                    msg_partial_i,
  input  logic                                    keccak_ready_i,
  input  logic                                    keccak_complete_i,
  input  logic                                    keccak_valid_i,
  output sha3_pad_pkg::mux_sel_e                  sel_mux_o,
  output logic                                    fsm_valid_o,
  output logic                                    hold_msg_o,
  output logic                                    en_msgbuf_o,
  output logic                                    clr_msgbuf_o,
  output logic                                    end_of_block_o,
  output logic [sha3_pad_pkg::keccak_count_w-1:0] sent_count_o,
  output logic                                    keccak_run_o,
  output logic                                    absorbed_o
);
  import sha3_pad_pkg::*;

  pad_st_e                   st_q, st_d;
  logic [keccak_count_w-1:0] sent_count_q;
  logic                      clr_sentmsg;
  logic                      keccak_ack;
  logic                      block_full;
  logic                      process_q;
  logic                      absorbed_d;

  ////////////////////////////////////////
  // beat counter and flags
  ////////////////////////////////////////

  assign keccak_ack = keccak_valid_i & keccak_ready_i;

  // counts accepted beats in the current block, doubling as the address
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sent_count_q <= '0;
    end else if (clr_sentmsg) begin
      sent_count_q <= '0;
    end else if (keccak_ack) begin
      sent_count_q <= sent_count_q + 1'b1;
    end
  end

  assign sent_count_o = sent_count_q;

  // all rate slots written, the permutation can run
  assign block_full     = (sent_count_q == block_limit_i);
  // the current beat lands in the last slot of the block
  assign end_of_block_o = ((sent_count_q + 1'b1) == block_limit_i);

  // process may arrive while the prefix is still going out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      process_q <= 1'b0;
    end else if (process_i) begin
      process_q <= 1'b1;
    end else if (done_i) begin
      process_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q       <= st_idle;
      absorbed_o <= 1'b0;
    end else begin
      st_q       <= st_d;
      absorbed_o <= absorbed_d;
    end
  end

  always_comb begin
    st_d         = st_q;
    sel_mux_o    = mux_none;
    fsm_valid_o  = 1'b0;
    hold_msg_o   = 1'b0;
    en_msgbuf_o  = 1'b0;
    clr_msgbuf_o = 1'b0;
    clr_sentmsg  = 1'b0;
    keccak_run_o = 1'b0;
    absorbed_d   = 1'b0;

    unique case (st_q)
      // the config is not latched yet, so the raw mode picks the path
      st_idle: begin
        if (start_i) begin
          st_d = (mode_i == cshake) ? st_prefix : st_message;
        end
      end

      // prefix words first, then zeros up to the block end
      st_prefix: begin
        sel_mux_o = mux_prefix;
        if (block_full) begin
          st_d         = st_prefix_wait;
          keccak_run_o = 1'b1;
          clr_sentmsg  = 1'b1;
        end else begin
          fsm_valid_o = 1'b1;
        end
      end

      st_prefix_wait: begin
        sel_mux_o = mux_prefix;
        if (keccak_complete_i) begin
          st_d = st_message;
        end
      end

      // a partial word is only buffered here and goes out in st_pad;
      // a full block wins over a pending process request
      st_message: begin
        sel_mux_o = mux_fifo;
        if (msg_valid_i && msg_partial_i) begin
          en_msgbuf_o = 1'b1;
        end else if (block_full) begin
          st_d         = st_message_wait;
          keccak_run_o = 1'b1;
          clr_sentmsg  = 1'b1;
          hold_msg_o   = 1'b1;
        end else if (process_q) begin
          st_d = st_pad;
        end
      end

      st_message_wait: begin
        sel_mux_o  = mux_fifo;
        hold_msg_o = 1'b1;
        if (keccak_complete_i) begin
          st_d = st_message;
        end
      end

      // buffered bytes plus function pad; in the last slot the word also
      // closes pad10*1 and no zero fill follows
      st_pad: begin
        sel_mux_o   = mux_funcpad;
        fsm_valid_o = 1'b1;
        if (keccak_ack && end_of_block_o) begin
          st_d         = st_pad_run;
          clr_msgbuf_o = 1'b1;
          clr_sentmsg  = 1'b1;
        end else if (keccak_ack) begin
          st_d         = st_pad01;
          clr_msgbuf_o = 1'b1;
        end
      end

      st_pad_run: begin
        st_d         = st_pad_flush;
        keccak_run_o = 1'b1;
        clr_sentmsg  = 1'b1;
      end

      // zero words, the last one carrying the closing 1 at bit 63
      st_pad01: begin
        sel_mux_o = mux_zero_end;
        if (block_full) begin
          st_d         = st_pad_flush;
          keccak_run_o = 1'b1;
          clr_sentmsg  = 1'b1;
        end else begin
          fsm_valid_o = 1'b1;
        end
      end

      // final permutation in flight
      st_pad_flush: begin
        clr_sentmsg  = 1'b1;
        clr_msgbuf_o = 1'b1;
        if (keccak_complete_i) begin
          st_d       = st_idle;
          absorbed_d = 1'b1;
        end
      end

      default: begin
        st_d = st_idle;
      end
    endcase
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  run_pulse_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    keccak_run_o |=> !keccak_run_o);

  absorbed_pulse_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    absorbed_o |=> !absorbed_o);

  // the datapath valid never points past the rate
  addr_in_rate_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    keccak_valid_i |-> sent_count_q < block_limit_i);

  // zero fill only starts when the pad word left slots open, so the
  // first cycle of st_pad01 has at least one zero word to send
  pad01_not_at_end_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (st_q == st_pad && st_d == st_pad01) |=> !block_full && sent_count_q != '0);

endmodule

//--- design/pad_datapath.sv
/*
  Padding datapath. Builds the word on the Keccak port from the message,
  the cSHAKE prefix, the buffered partial word merged with the function
  pad, or the zero-fill word, and steers valid and ready by the FSM mux.
*/
`timescale 1ns/1ps

module pad_datapath (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    msg_valid_i,
  input  logic [sha3_pad_pkg::msg_width-1:0]      msg_data_i,
  input  logic [sha3_pad_pkg::msg_strb_w-1:0]     msg_strb_i,
  input  logic [sha3_pad_pkg::ns_bytes*8-1:0]     ns_data_i,
  input  logic [15:0]                             bytepad_hdr_i,
  input  logic [4:0]                              funcpad_i,
  input  sha3_pad_pkg::mux_sel_e                  sel_mux_i,
  input  logic                                    fsm_valid_i,
  input  logic                                    hold_msg_i,
  input  logic                                    en_msgbuf_i,
  input  logic                                    clr_msgbuf_i,
  input  logic                                    end_of_block_i,
  input  logic [sha3_pad_pkg::keccak_count_w-1:0] sent_count_i,
  input  logic                                    keccak_ready_i,
  output logic                                    msg_partial_o,
  output logic                                    msg_ready_o,
  output logic                                    keccak_valid_o,
  output logic [sha3_pad_pkg::keccak_addr_w-1:0]  keccak_addr_o,
  output logic [sha3_pad_pkg::msg_width-1:0]      keccak_data_o
);
  import sha3_pad_pkg::*;

  logic [prefix_words*msg_width-1:0] prefix;
  logic [msg_width-1:0]              prefix_word;
  logic [msg_width-9:0]              msg_buf_q;
  logic [msg_strb_w-2:0]             msg_strb_q;
  logic [2:0]                        pad_byte;
  logic [msg_width-1:0]              pad_word;
  logic [msg_width-1:0]              zero_end_word;

  ////////////////////////////////////////
  // prefix
  ////////////////////////////////////////

  // header in the two low bytes, the N/S string behind it
  assign prefix = {ns_data_i, bytepad_hdr_i};

  // slots past the prefix read as zero, which is the bytepad fill
  always_comb begin
    prefix_word = '0;
    for (int i = 0; i < prefix_words; i++) begin
      if (sent_count_i == keccak_count_w'(i)) prefix_word = prefix[msg_width*i +: msg_width];
    end
  end

  ////////////////////////////////////////
  // partial word buffer and pad word
  ////////////////////////////////////////

  // only a message's last word may leave strobes low
  assign msg_partial_o = ~&msg_strb_i;

  // a partial word has at most 7 bytes, so byte 7 is never kept
  always_ff @(posedge clk_i) begin
    if (en_msgbuf_i) begin
      msg_buf_q <= msg_data_i[msg_width-9:0];
    end
  end

  // the strobes decide which buffered bytes are real
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msg_strb_q <= '0;
    end else if (en_msgbuf_i) begin
      msg_strb_q <= msg_strb_i[msg_strb_w-2:0];
    end else if (clr_msgbuf_i) begin
      msg_strb_q <= '0;
    end
  end

  // strobes are contiguous from byte 0, so the highest set one gives
  // the count of kept bytes
  always_comb begin
    pad_byte = 3'd0;
    for (int i = 0; i < msg_strb_w - 1; i++) begin
      if (msg_strb_q[i]) pad_byte = 3'(i + 1);
    end
  end

  // kept bytes, function pad in the next byte, pad10*1 end bit on top
  always_comb begin
    pad_word = '0;
    for (int i = 0; i < msg_strb_w - 1; i++) begin
      if (msg_strb_q[i]) pad_word[8*i +: 8] = msg_buf_q[8*i +: 8];
    end
    pad_word[8*pad_byte +: 5] = funcpad_i;
    pad_word[msg_width-1]     = end_of_block_i;
  end

  assign zero_end_word = {end_of_block_i, {(msg_width-1){1'b0}}};

  ////////////////////////////////////////
  // output mux
  ////////////////////////////////////////

  assign keccak_addr_o = sent_count_i;

  always_comb begin
    unique case (sel_mux_i)
      mux_fifo:     keccak_data_o = msg_data_i;
      mux_prefix:   keccak_data_o = prefix_word;
      mux_funcpad:  keccak_data_o = pad_word;
      mux_zero_end: keccak_data_o = zero_end_word;
      default:      keccak_data_o = '0;
    endcase
  end

  // a buffered partial word is acked without going to the Keccak port
  always_comb begin
    keccak_valid_o = 1'b0;
    msg_ready_o    = 1'b0;
    unique case (sel_mux_i)
      mux_fifo: begin
        keccak_valid_o = msg_valid_i & ~hold_msg_i & ~en_msgbuf_i;
        msg_ready_o    = en_msgbuf_i | (keccak_ready_i & ~hold_msg_i);
      end
      mux_prefix, mux_funcpad, mux_zero_end: begin
        keccak_valid_o = fsm_valid_i;
      end
      default: begin
        keccak_valid_o = 1'b0;
      end
    endcase
  end

  // the FSM only buffers words whose top byte strobe is low
  msgbuf_partial_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    en_msgbuf_i |-> msg_valid_i && !msg_strb_i[msg_strb_w-1]);

endmodule

//--- design/sha3_pad.sv
/*
  SHA-3 sponge padding unit. Feeds message words, an optional cSHAKE
  prefix and the final padding into the rate of an external Keccak
  state, requesting one permutation per block.
*/
`timescale 1ns/1ps

module sha3_pad (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // message stream
  input  logic                                   msg_valid_i,
  input  logic [sha3_pad_pkg::msg_width-1:0]     msg_data_i,
  input  logic [sha3_pad_pkg::msg_strb_w-1:0]    msg_strb_i,
  output logic                                   msg_ready_o,
  // encoded N/S string, only read in cSHAKE
  input  logic [sha3_pad_pkg::ns_bytes*8-1:0]    ns_data_i,
  // writes into the Keccak rate
  output logic                                   keccak_valid_o,
  output logic [sha3_pad_pkg::keccak_addr_w-1:0] keccak_addr_o,
  output logic [sha3_pad_pkg::msg_width-1:0]     keccak_data_o,
  input  logic                                   keccak_ready_i,
  // permutation handshake
  output logic                                   keccak_run_o,
  input  logic                                   keccak_complete_i,
  // configuration, captured on start
  input  sha3_pad_pkg::sha3_mode_e               mode_i,
  input  sha3_pad_pkg::keccak_strength_e         strength_i,
  // operation pulses
  input  logic                                   start_i,
  input  logic                                   process_i,
  input  logic                                   done_i,
  output logic                                   absorbed_o
);
  import sha3_pad_pkg::*;

  logic                      is_cshake;
  logic [keccak_count_w-1:0] block_limit;
  logic [4:0]                funcpad;
  logic [15:0]               bytepad_hdr;
  mux_sel_e                  sel_mux;
  logic                      fsm_valid;
  logic                      hold_msg;
  logic                      en_msgbuf;
  logic                      clr_msgbuf;
  logic                      end_of_block;
  logic [keccak_count_w-1:0] sent_count;
  logic                      msg_partial;

  pad_config pad_config_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .mode_i        (mode_i),
    .strength_i    (strength_i),
    .is_cshake_o   (is_cshake),
    .block_limit_o (block_limit),
    .funcpad_o     (funcpad),
    .bytepad_hdr_o (bytepad_hdr)
  );

  pad_fsm pad_fsm_inst (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .start_i           (start_i),
    .process_i         (process_i),
    .done_i            (done_i),
    .mode_i            (mode_i),
    .block_limit_i     (block_limit),
    .msg_valid_i       (msg_valid_i),
    .msg_partial_i     (msg_partial),
    .keccak_ready_i    (keccak_ready_i),
    .keccak_complete_i (keccak_complete_i),
    .keccak_valid_i    (keccak_valid_o),
    .sel_mux_o         (sel_mux),
    .fsm_valid_o       (fsm_valid),
    .hold_msg_o        (hold_msg),
    .en_msgbuf_o       (en_msgbuf),
    .clr_msgbuf_o      (clr_msgbuf),
    .end_of_block_o    (end_of_block),
    .sent_count_o      (sent_count),
    .keccak_run_o      (keccak_run_o),
    .absorbed_o        (absorbed_o)
  );

  pad_datapath pad_datapath_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .msg_valid_i    (msg_valid_i),
    .msg_data_i     (msg_data_i),
    .msg_strb_i     (msg_strb_i),
    .ns_data_i      (ns_data_i),
    .bytepad_hdr_i  (bytepad_hdr),
    .funcpad_i      (funcpad),
    .sel_mux_i      (sel_mux),
    .fsm_valid_i    (fsm_valid),
    .hold_msg_i     (hold_msg),
    .en_msgbuf_i    (en_msgbuf),
    .clr_msgbuf_i   (clr_msgbuf),
    .end_of_block_i (end_of_block),
    .sent_count_i   (sent_count),
    .keccak_ready_i (keccak_ready_i),
    .msg_partial_o  (msg_partial),
    .msg_ready_o    (msg_ready_o),
    .keccak_valid_o (keccak_valid_o),
    .keccak_addr_o  (keccak_addr_o),
    .keccak_data_o  (keccak_data_o)
  );

  // the FSM picks the prefix path from the raw mode, the config from the
  // latched one, and both must agree on every prefix beat
  prefix_only_cshake_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    keccak_valid_o && sel_mux == mux_prefix |-> is_cshake);

endmodule

//--- tb/tb_sha3_pad.sv
/*
  Testbench for the SHA-3 padding unit. Runs random messages in every legal
  mode and strength, plays the Keccak permutation with random back-pressure
  and checks each absorbed block against a padding model of the sponge rules.
*/
`timescale 1ns/1ps

module tb_sha3_pad;
  import sha3_pad_pkg::*;

  localparam int num_tests       = 20;
  localparam int cycles_per_test = 400;
  localparam int timeout_cycles  = num_tests * cycles_per_test;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        msg_valid_i;
  logic [msg_width-1:0]        msg_data_i;
  logic [msg_strb_w-1:0]       msg_strb_i;
  logic                        msg_ready_o;
  logic [ns_bytes*8-1:0]       ns_data_i;
  logic                        keccak_valid_o;
  logic [keccak_addr_w-1:0]    keccak_addr_o;
  logic [msg_width-1:0]        keccak_data_o;
  logic                        keccak_ready_i;
  logic                        keccak_run_o;
  logic                        keccak_complete_i;
  sha3_mode_e                  mode_i;
  keccak_strength_e            strength_i;
  logic                        start_i;
  logic                        process_i;
  logic                        done_i;
  logic                        absorbed_o;

  int seed = 8977;
  // back-pressure draws from its own stream so stimulus order cannot shift it
  int ready_seed = 8977 * 3;

  // current operation, written by the test sequence before start
  sha3_mode_e       cur_mode;
  keccak_strength_e cur_strength;
  int               cur_rate;
  int               nwords;
  int               last_bytes;
  int               nblocks;
  logic [63:0]      msg_q [$];
  logic [63:0]      exp_q [$];

  int run_total;
  int run_base;
  int absorbed_total;
  int absorbed_base;
  logic in_prefix;
  logic run_pending;
  int errors;
  int checks;

  sha3_pad sha3_pad_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk_i);
    $display("timeout: the DUT did not finish %0d tests in %0d cycles", num_tests,
             timeout_cycles);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // checks and model
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    checks++;
    if (got !== expected) begin
      $display("mismatch %s: got %h expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("error: %s", msg);
    errors++;
  endtask

  // rate of the sponge in 64-bit words, 1600 bits minus twice the strength
  function automatic int rate_words(input keccak_strength_e s);
    case (s)
      l128:    return 21;
      l224:    return 18;
      l256:    return 17;
      l384:    return 13;
      default: return 9;
    endcase
  endfunction

  // domain separation bits with the leading 1 of pad10*1
  function automatic logic [7:0] funcpad_byte(input sha3_mode_e m);
    case (m)
      sha3:    return 8'h06;
      shake:   return 8'h1f;
      default: return 8'h04;
    endcase
  endfunction

  task automatic build_expected();
    logic [7:0]  pre [48];
    logic [63:0] w;
    logic [63:0] pad;
    int          kept;
    int          full_words;
    int          i;
    int          j;
    exp_q.delete();
    // bytepad(encode_string(N) || encode_string(S), rate) as one whole block
    if (cur_mode == cshake) begin
      pre[0] = 8'h01;
      pre[1] = 8'(cur_rate * 8);
      for (i = 0; i < ns_bytes; i++) pre[i + 2] = ns_data_i[8*i +: 8];
      for (j = 0; j < cur_rate; j++) begin
        w = '0;
        if (j < 6) begin
          for (i = 0; i < 8; i++) w[8*i +: 8] = pre[8*j + i];
        end
        exp_q.push_back(w);
      end
    end
    kept       = (nwords > 0 && last_bytes < 8) ? last_bytes : 0;
    full_words = (kept > 0) ? nwords - 1 : nwords;
    for (j = 0; j < full_words; j++) exp_q.push_back(msg_q[j]);
    pad = '0;
    for (i = 0; i < kept; i++) pad[8*i +: 8] = msg_q[nwords - 1][8*i +: 8];
    pad[8*kept +: 8] = funcpad_byte(cur_mode);
    // the closing 1 of pad10*1 sits in bit 63 of the block's last word
    if ((exp_q.size() % cur_rate) == cur_rate - 1) begin
      pad[63] = 1'b1;
      exp_q.push_back(pad);
    end else begin
      exp_q.push_back(pad);
      while ((exp_q.size() % cur_rate) != cur_rate - 1) exp_q.push_back('0);
      exp_q.push_back(64'h8000_0000_0000_0000);
    end
    nblocks = exp_q.size() / cur_rate;
  endtask

  ////////////////////////////////////////
  // Keccak model and bus monitor
  ////////////////////////////////////////

  // random ready, and a completion pulse 3 to 8 cycles after each run
  initial begin
    int delay;
    int runs_served;
    keccak_ready_i    = 1'b0;
    keccak_complete_i = 1'b0;
    delay             = 0;
    runs_served       = 0;
    forever begin
      @(negedge clk_i);
      keccak_ready_i    = ($random(ready_seed) & 3) != 0;
      keccak_complete_i = 1'b0;
      if (runs_served != run_total) begin
        runs_served = run_total;
        delay       = 3 + $unsigned($random(ready_seed)) % 6;
      end else if (delay > 0) begin
        delay--;
        if (delay == 0) keccak_complete_i = 1'b1;
      end
    end
  end

  // sampled on the rising edge, where every DUT output is settled
  initial begin
    logic [63:0] img [21];
    logic [20:0] written;
    logic        prev_complete;
    int          blk;
    int          i;
    written       = '0;
    prev_complete = 1'b0;
    in_prefix     = 1'b0;
    run_pending   = 1'b0;
    forever begin
      @(posedge clk_i);
      if (rst_ni) begin
        if (in_prefix || run_pending || keccak_run_o) begin
          check_value("msg_ready_o", 64'(msg_ready_o), 64'd0);
        end
        if (keccak_valid_o && keccak_ready_i) begin
          if (int'(keccak_addr_o) >= cur_rate) begin
            report_error($sformatf("write to slot %0d beyond the rate", keccak_addr_o));
          end else if (written[keccak_addr_o]) begin
            report_error($sformatf("slot %0d written twice in one block", keccak_addr_o));
          end else begin
            img[keccak_addr_o]     = keccak_data_o;
            written[keccak_addr_o] = 1'b1;
          end
        end
        if (keccak_run_o) begin
          blk = run_total - run_base;
          if (blk >= nblocks) begin
            report_error("permutation requested with no block left to absorb");
          end else begin
            for (i = 0; i < cur_rate; i++) begin
              if (!written[i]) begin
                report_error($sformatf("block %0d slot %0d not written before run", blk, i));
              end else begin
                check_value($sformatf("keccak_data_o block %0d word %0d", blk, i), img[i],
                            exp_q[blk * cur_rate + i]);
              end
            end
          end
          written     = '0;
          run_total   = run_total + 1;
          run_pending = 1'b1;
        end
        if (keccak_complete_i) begin
          run_pending = 1'b0;
          in_prefix   = 1'b0;
        end
        if (absorbed_o) begin
          if (!prev_complete) report_error("absorbed pulse did not follow a completion");
          check_value("keccak_run_o count at absorbed_o", 64'(run_total - run_base),
                      64'(nblocks));
          absorbed_total = absorbed_total + 1;
        end
        prev_complete = keccak_complete_i;
        if (start_i && mode_i == cshake) in_prefix = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // valid stays up until the word is taken, gaps only between words
  task automatic send_message();
    int   w;
    logic taken;
    w     = 0;
    taken = 1'b0;
    while (w < nwords) begin
      @(negedge clk_i);
      if (!msg_valid_i || taken) begin
        taken = 1'b0;
        if (($random(seed) & 3) == 0) begin
          msg_valid_i = 1'b0;
        end else begin
          msg_valid_i = 1'b1;
          msg_data_i  = msg_q[w];
          msg_strb_i  = (w == nwords - 1) ? 8'((1 << last_bytes) - 1) : 8'hff;
        end
      end
      @(posedge clk_i);
      if (msg_valid_i && msg_ready_o) begin
        w++;
        taken = 1'b1;
      end
    end
  endtask

  task automatic run_test(input int t);
    int pick;
    int i;
    int errors_before;
    errors_before = errors;
    pick = $unsigned($random(seed)) % 8;
    if (pick < 4) cur_mode = sha3;
    else if (pick < 6) cur_mode = shake;
    else cur_mode = cshake;
    case (pick)
      0:       cur_strength = l224;
      1:       cur_strength = l256;
      2:       cur_strength = l384;
      3:       cur_strength = l512;
      4, 6:    cur_strength = l128;
      default: cur_strength = l256;
    endcase
    cur_rate   = rate_words(cur_strength);
    nwords     = $unsigned($random(seed)) % 41;
    last_bytes = 1 + $unsigned($random(seed)) % 8;
    msg_q.delete();
    for (i = 0; i < nwords; i++) msg_q.push_back({$random(seed), $random(seed)});
    for (i = 0; i < ns_bytes; i++) ns_data_i[8*i +: 8] = 8'($random(seed));
    build_expected();
    run_base      = run_total;
    absorbed_base = absorbed_total;

    @(negedge clk_i);
    start_i    = 1'b1;
    mode_i     = cur_mode;
    strength_i = cur_strength;
    @(negedge clk_i);
    start_i = 1'b0;
    send_message();
    @(negedge clk_i);
    msg_valid_i = 1'b0;
    process_i   = 1'b1;
    @(negedge clk_i);
    process_i = 1'b0;
    @(posedge clk_i);
    while (!absorbed_o) @(posedge clk_i);
    @(negedge clk_i);
    done_i = 1'b1;
    @(negedge clk_i);
    done_i = 1'b0;
    repeat (2) @(negedge clk_i);

    check_value("keccak_run_o count", 64'(run_total - run_base), 64'(nblocks));
    check_value("absorbed_o count", 64'(absorbed_total - absorbed_base), 64'd1);
    $display("test %0d %s %s words %0d last bytes %0d blocks %0d: %s", t, cur_mode.name(),
             cur_strength.name(), nwords, last_bytes, nblocks,
             (errors == errors_before) ? "pass" : "fail");
  endtask

  initial begin
    int t;
    errors         = 0;
    checks         = 0;
    run_total      = 0;
    run_base       = 0;
    absorbed_total = 0;
    absorbed_base  = 0;
    cur_rate       = 21;
    nblocks        = 0;
    rst_ni         = 1'b0;
    msg_valid_i    = 1'b0;
    msg_data_i     = '0;
    msg_strb_i     = 8'hff;
    ns_data_i      = '0;
    mode_i         = sha3;
    strength_i     = l256;
    start_i        = 1'b0;
    process_i      = 1'b0;
    done_i         = 1'b0;
    repeat (3) @(negedge clk_i);
    check_value("keccak_valid_o in reset", 64'(keccak_valid_o), 64'd0);
    check_value("msg_ready_o in reset", 64'(msg_ready_o), 64'd0);
    check_value("keccak_run_o in reset", 64'(keccak_run_o), 64'd0);
    check_value("absorbed_o in reset", 64'(absorbed_o), 64'd0);
    rst_ni = 1'b1;

    for (t = 0; t < num_tests; t++) run_test(t);

    $display("tests %0d, checks %0d, errors %0d", num_tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
design/sha3_pad_pkg.sv
design/pad_config.sv
design/pad_fsm.sv
design/pad_datapath.sv
design/sha3_pad.sv
tb/tb_sha3_pad.sv

//--- run.sh
#!/bin/sh
# Builds the SHA-3 padding testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_sha3_pad \
  --Mdir obj_dir -o tb_sha3_pad -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sha3_pad > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
